// ==== chan_node.f ====
common/chan_stream_pkg.sv
common/chan_map_pkg.sv
src/chan_rx_demux.sv
src/user_regs.sv
frame_buf/frame_buf.sv
src/chan_tx_arbiter.sv
src/chan_node_top.sv
verification/chan_node_model.sv
verification/chan_node_tb.sv

// ==== common/chan_map_pkg.sv ====
// Port numbers are fixed here; unused ports are consumed by the demux and never replied to
package chan_map_pkg;

	import chan_stream_pkg::*;

	// --------------------
	// Channel port map
	// --------------------

	// Registered DIP switches, one-beat reply
	localparam port_t PORT_DIP    = 4'd1;
	// LED register write, echoes new value
	localparam port_t PORT_LED    = 4'd2;
	// Frame buffer store
	localparam port_t PORT_BUF_WR = 4'd3;
	// Frame buffer replay
	localparam port_t PORT_BUF_RD = 4'd4;

	// Reply sources seen by the return arbiter
	typedef enum logic {
		REGS = 1'b0,
		BUF  = 1'b1
	} src_sel_t;

endpackage

// ==== common/chan_stream_pkg.sv ====
// Byte-wide stream types only; beats carry no byte enables and a frame is always sof..eof
package chan_stream_pkg;

	// --------------------
	// Plain vector widths
	// --------------------

	// One payload byte on any stream
	typedef logic [7:0] byte_t;

	// Channel port address, 16 ports on the platform
	typedef logic [3:0] port_t;

	// --------------------
	// Stream beats
	// --------------------

	// One beat as seen on the platform stream
	// sof and eof may both be set for a one-byte frame
	typedef struct packed {
		logic  sof;
		logic  eof;
		byte_t data;
	} beat_t;

	// Reply beat tagged with the port it returns on
	// Port must stay constant for the whole frame
	typedef struct packed {
		port_t port;
		beat_t beat;
	} reply_t;

endpackage

// ==== frame_buf/frame_buf.sv ====
// BUF_DEPTH must be a power of two from 4 to 256; longer frames are cut to BUF_DEPTH bytes
module frame_buf
	import chan_stream_pkg::*, chan_map_pkg::*;
#(
	parameter int BUF_DEPTH = 16
)
(
	input  logic   clk_local,
	input  logic   rst_local,

	// Request side from demux
	input  beat_t  req_beat,
	input  logic   req_valid,
	input  port_t  req_port,
	output logic   ready,

	// Reply side to arbiter
	output reply_t rep,
	output logic   rep_src_rdy,
	input  logic   rep_dst_rdy
);

	localparam int AW = $clog2(BUF_DEPTH);

	// Byte count, one bit wider than the address to hold BUF_DEPTH
	typedef logic [AW:0] len_t;

	localparam len_t DEPTH_L = len_t'(BUF_DEPTH);

	typedef enum logic [1:0] {
		IDLE,
		STORE,
		REPLAY
	} fb_state_t;

	fb_state_t state;

	byte_t mem [BUF_DEPTH];
	len_t  wr_ptr;
	len_t  stored_len;
	len_t  rd_ptr;

	len_t  wr_idx;
	logic  beat_xfer;
	logic  store_beat;
	logic  replay_req;
	logic  rep_xfer;

	// No new beats while the stored frame is going out
	assign ready     = (state != REPLAY);
	assign beat_xfer = req_valid & ready;

	assign store_beat = beat_xfer & (req_port == PORT_BUF_WR);
	assign replay_req = beat_xfer & (req_port == PORT_BUF_RD) & req_beat.eof;
	assign rep_xfer   = rep_src_rdy & rep_dst_rdy;

	// A sof always restarts at the bottom of the buffer
	assign wr_idx = (state == STORE && !req_beat.sof) ? wr_ptr : '0;

	// --------------------
	// Store path
	// --------------------

	// Bytes past the end are dropped
	always_ff @(posedge clk_local)
	begin
		if (store_beat && wr_idx < DEPTH_L)
			mem[wr_idx[AW-1:0]] <= req_beat.data;
	end

	// --------------------
	// Control FSM
	// --------------------

	always_ff @(posedge clk_local)
	begin
		if (rst_local)
		begin
			state      <= IDLE;
			wr_ptr     <= '0;
			stored_len <= '0;
			rd_ptr     <= '0;
		end
		else
		begin
			case (state)
				IDLE, STORE:
				begin
					if (store_beat)
					begin
						// Length follows the write pointer, saturating at depth
						if (wr_idx < DEPTH_L)
						begin
							wr_ptr     <= wr_idx + len_t'(1);
							stored_len <= wr_idx + len_t'(1);
						end
						state <= req_beat.eof ? IDLE : STORE;
					end
					else if (replay_req)
					begin
						rd_ptr <= '0;
						state  <= REPLAY;
					end
				end
				REPLAY:
				begin
					if (rep_xfer)
					begin
						if (rep.beat.eof)
							state <= IDLE;
						else
							rd_ptr <= rd_ptr + len_t'(1);
					end
				end
				default:
				begin
					state <= IDLE;
				end
			endcase
		end
	end

	// --------------------
	// Replay output
	// --------------------

	// Empty buffer replies with a single zero byte
	always_comb
	begin
		rep.port     = PORT_BUF_RD;
		rep.beat.sof = (rd_ptr == '0);
		if (stored_len == '0)
		begin
			rep.beat.eof  = 1'b1;
			rep.beat.data = '0;
		end
		else
		begin
			rep.beat.eof  = (rd_ptr == stored_len - len_t'(1));
			rep.beat.data = mem[rd_ptr[AW-1:0]];
		end
	end

	assign rep_src_rdy = (state == REPLAY);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f chan_node.f --top-module chan_node_tb -o chan_node_sim

out=$(./obj_dir/chan_node_sim) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "All tests passed!"
then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

// ==== src/chan_node_top.sv ====
// Platform stream boundary only; the serial link, MAC and I/O buffers sit outside this block
module chan_node_top
	import chan_stream_pkg::*;
#(
	parameter int BUF_DEPTH = 16
)
(
	input  logic  clk_local,
	input  logic  rst_local,

	// Platform to user
	input  beat_t out_beat,
	input  logic  out_src_rdy,
	input  port_t outport,
	output logic  out_dst_rdy,

	// User to platform
	output beat_t in_beat,
	output logic  in_src_rdy,
	input  logic  in_dst_rdy,
	output port_t inport,

	// Board I/O
	input  byte_t dip,
	output byte_t leds
);

	// Demux to channels
	beat_t  regs_beat;
	logic   regs_valid;
	port_t  regs_port;
	logic   regs_ready;
	beat_t  buf_beat;
	logic   buf_valid;
	port_t  buf_port;
	logic   buf_ready;

	// Channels to arbiter
	reply_t regs_rep;
	logic   regs_src_rdy;
	logic   regs_dst_rdy;
	reply_t buf_rep;
	logic   buf_src_rdy;
	logic   buf_dst_rdy;

	chan_rx_demux u_demux (
		.out_beat    (out_beat),
		.out_src_rdy (out_src_rdy),
		.outport     (outport),
		.out_dst_rdy (out_dst_rdy),
		.regs_beat   (regs_beat),
		.regs_valid  (regs_valid),
		.regs_port   (regs_port),
		.regs_ready  (regs_ready),
		.buf_beat    (buf_beat),
		.buf_valid   (buf_valid),
		.buf_port    (buf_port),
		.buf_ready   (buf_ready)
	);

	// Ports 1 and 2
	user_regs u_regs (
		.clk_local   (clk_local),
		.rst_local   (rst_local),
		.dip         (dip),
		.leds        (leds),
		.req_beat    (regs_beat),
		.req_valid   (regs_valid),
		.req_port    (regs_port),
		.ready       (regs_ready),
		.rep         (regs_rep),
		.rep_src_rdy (regs_src_rdy),
		.rep_dst_rdy (regs_dst_rdy)
	);

	// Ports 3 and 4
	frame_buf #(
		.BUF_DEPTH (BUF_DEPTH)
	) u_buf (
		.clk_local   (clk_local),
		.rst_local   (rst_local),
		.req_beat    (buf_beat),
		.req_valid   (buf_valid),
		.req_port    (buf_port),
		.ready       (buf_ready),
		.rep         (buf_rep),
		.rep_src_rdy (buf_src_rdy),
		.rep_dst_rdy (buf_dst_rdy)
	);

	chan_tx_arbiter u_arb (
		.clk_local    (clk_local),
		.rst_local    (rst_local),
		.regs_rep     (regs_rep),
		.regs_src_rdy (regs_src_rdy),
		.regs_dst_rdy (regs_dst_rdy),
		.buf_rep      (buf_rep),
		.buf_src_rdy  (buf_src_rdy),
		.buf_dst_rdy  (buf_dst_rdy),
		.in_beat      (in_beat),
		.inport       (inport),
		.in_src_rdy   (in_src_rdy),
		.in_dst_rdy   (in_dst_rdy)
	);

endmodule

// ==== src/chan_rx_demux.sv ====
// Purely combinational; relies on outport staying stable from sof to eof of each frame
module chan_rx_demux
	import chan_stream_pkg::*, chan_map_pkg::*;
(
	// Platform downstream
	input  beat_t out_beat,
	input  logic  out_src_rdy,
	input  port_t outport,
	output logic  out_dst_rdy,

	// Register channel, ports 1 and 2
	output beat_t regs_beat,
	output logic  regs_valid,
	output port_t regs_port,
	input  logic  regs_ready,

	// Frame buffer channel, ports 3 and 4
	output beat_t buf_beat,
	output logic  buf_valid,
	output port_t buf_port,
	input  logic  buf_ready
);

	// Port ownership decode
	logic to_regs;
	logic to_buf;

	always_comb
	begin
		to_regs = 1'b0;
		to_buf  = 1'b0;
		case (outport)
			PORT_DIP, PORT_LED:
			begin
				to_regs = 1'b1;
			end
			PORT_BUF_WR, PORT_BUF_RD:
			begin
				to_buf = 1'b1;
			end
			default:
			begin
				// Unowned port, beat is swallowed
				to_regs = 1'b0;
				to_buf  = 1'b0;
			end
		endcase
	end

	// --------------------
	// Forward paths
	// --------------------

	// Beat and port fan out to both channels
	// Only the strobe picks the owner
	assign regs_beat  = out_beat;
	assign regs_port  = outport;
	assign regs_valid = out_src_rdy & to_regs;

	assign buf_beat   = out_beat;
	assign buf_port   = outport;
	assign buf_valid  = out_src_rdy & to_buf;

	// --------------------
	// Back-pressure
	// --------------------

	// Owner's ready, or always accept for dropped ports
	always_comb
	begin
		if (to_regs)
			out_dst_rdy = regs_ready;
		else if (to_buf)
			out_dst_rdy = buf_ready;
		else
			out_dst_rdy = 1'b1;
	end

endmodule

// ==== src/chan_tx_arbiter.sv ====
// Two sources only; a source keeps the stream from sof to eof, so frames never interleave
module chan_tx_arbiter
	import chan_stream_pkg::*, chan_map_pkg::*;
(
	input  logic   clk_local,
	input  logic   rst_local,

	// Reply sources
	input  reply_t regs_rep,
	input  logic   regs_src_rdy,
	output logic   regs_dst_rdy,
	input  reply_t buf_rep,
	input  logic   buf_src_rdy,
	output logic   buf_dst_rdy,

	// Platform return stream
	output beat_t  in_beat,
	output port_t  inport,
	output logic   in_src_rdy,
	input  logic   in_dst_rdy
);

	// Frame lock
	logic     locked;
	src_sel_t owner;
	src_sel_t pref;

	// Output stage
	reply_t   out_rep;
	logic     out_valid;

	src_sel_t sel;
	logic     sel_rdy;
	reply_t   sel_rep;
	logic     load_en;
	logic     take;

	// --------------------
	// Source select
	// --------------------

	// Locked source wins, else preferred, else whoever is ready
	always_comb
	begin
		if (locked)
			sel = owner;
		else if (pref == REGS)
			sel = (!regs_src_rdy && buf_src_rdy) ? BUF : REGS;
		else
			sel = (!buf_src_rdy && regs_src_rdy) ? REGS : BUF;
	end

	assign sel_rdy = (sel == REGS) ? regs_src_rdy : buf_src_rdy;
	assign sel_rep = (sel == REGS) ? regs_rep : buf_rep;

	// Stage empty or draining this cycle
	assign load_en = ~out_valid | in_dst_rdy;
	assign take    = load_en & sel_rdy;

	assign regs_dst_rdy = load_en & (sel == REGS);
	assign buf_dst_rdy  = load_en & (sel == BUF);

	// --------------------
	// Lock and preference
	// --------------------

	always_ff @(posedge clk_local)
	begin
		if (rst_local)
		begin
			locked <= 1'b0;
			owner  <= REGS;
			pref   <= REGS;
		end
		else if (take)
		begin
			if (sel_rep.beat.eof)
			begin
				// Frame done, other side gets first pick
				locked <= 1'b0;
				pref   <= (sel == REGS) ? BUF : REGS;
			end
			else
			begin
				locked <= 1'b1;
				owner  <= sel;
			end
		end
	end

	// --------------------
	// Output register
	// --------------------

	always_ff @(posedge clk_local)
	begin
		if (rst_local)
			out_valid <= 1'b0;
		else if (load_en)
			out_valid <= sel_rdy;
	end

	// Holds while stalled
	always_ff @(posedge clk_local)
	begin
		if (take)
			out_rep <= sel_rep;
	end

	assign in_beat    = out_rep.beat;
	assign inport     = out_rep.port;
	assign in_src_rdy = out_valid;

endmodule

// ==== src/user_regs.sv ====
// Ports 1 and 2 only; every request gets a one-beat reply and at most two may wait unsent
module user_regs
	import chan_stream_pkg::*, chan_map_pkg::*;
(
	input  logic   clk_local,
	input  logic   rst_local,

	// Switches and LEDs
	input  byte_t  dip,
	output byte_t  leds,

	// Request side from demux
	input  beat_t  req_beat,
	input  logic   req_valid,
	input  port_t  req_port,
	output logic   ready,

	// Reply side to arbiter
	output reply_t rep,
	output logic   rep_src_rdy,
	input  logic   rep_dst_rdy
);

	byte_t  dip_r;

	// Two-entry reply FIFO
	reply_t fifo_mem [2];
	logic   wr_ptr;
	logic   rd_ptr;
	logic   [1:0] count;

	reply_t new_rep;
	logic   beat_xfer;
	logic   push;
	logic   pop;

	// Free slot means a beat can be taken
	assign ready     = (count != 2'd2);
	assign beat_xfer = req_valid & ready;

	// Only the eof beat of a port 1 or 2 frame queues a reply
	assign push = beat_xfer & req_beat.eof & ((req_port == PORT_DIP) | (req_port == PORT_LED));
	assign pop  = rep_src_rdy & rep_dst_rdy;

	// One-beat reply; LED port echoes the byte being written
	always_comb
	begin
		new_rep.port      = req_port;
		new_rep.beat.sof  = 1'b1;
		new_rep.beat.eof  = 1'b1;
		new_rep.beat.data = (req_port == PORT_LED) ? req_beat.data : dip_r;
	end

	// --------------------
	// Registers
	// --------------------

	// Switch sampling, every cycle
	always_ff @(posedge clk_local)
	begin
		dip_r <= dip;
	end

	// LED register, last beat of the frame wins
	always_ff @(posedge clk_local)
	begin
		if (rst_local)
			leds <= '0;
		else if (beat_xfer && req_port == PORT_LED)
			leds <= req_beat.data;
	end

	// FIFO storage
	always_ff @(posedge clk_local)
	begin
		if (push)
			fifo_mem[wr_ptr] <= new_rep;
	end

	// FIFO pointers and fill level
	always_ff @(posedge clk_local)
	begin
		if (rst_local)
		begin
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
			count  <= 2'd0;
		end
		else
		begin
			if (push)
				wr_ptr <= ~wr_ptr;
			if (pop)
				rd_ptr <= ~rd_ptr;
			// Push and pop together leave the level unchanged
			if (push && !pop)
				count <= count + 2'd1;
			else if (pop && !push)
				count <= count - 2'd1;
		end
	end

	assign rep         = fifo_mem[rd_ptr];
	assign rep_src_rdy = (count != 2'd0);

endmodule

// ==== verification/chan_node_model.sv ====
// Expected replies only; beats must be reported in acceptance order and DIP held while replies wait
module chan_node_model
	import chan_stream_pkg::*, chan_map_pkg::*;
#(
	parameter int BUF_DEPTH = 16
)
();

	timeunit 1ns;
	timeprecision 1ps;

	// Board state mirror
	byte_t led_val = '0;
	byte_t dip_val = '0;

	// Stored frame, never longer than BUF_DEPTH
	byte_t buf_q [$];

	// --------------------
	// Expected reply queues
	// --------------------

	reply_t q_dip [$];
	reply_t q_led [$];
	reply_t q_rd  [$];

	function automatic reply_t make_reply(port_t port, byte_t data, logic sof, logic eof);
		reply_t r;
		r.port      = port;
		r.beat.sof  = sof;
		r.beat.eof  = eof;
		r.beat.data = data;
		return r;
	endfunction

	task automatic set_dip(input byte_t value);
		dip_val = value;
	endtask

	function automatic byte_t led_state();
		return led_val;
	endfunction

	function automatic int pending();
		return q_dip.size() + q_led.size() + q_rd.size();
	endfunction

	// One accepted request beat
	task automatic accept_beat(input port_t port, input beat_t beat);
		int i;
		case (port)
			PORT_DIP:
			begin
				if (beat.eof)
					q_dip.push_back(make_reply(PORT_DIP, dip_val, 1'b1, 1'b1));
			end
			PORT_LED:
			begin
				// Every byte lands, last one sticks
				led_val = beat.data;
				if (beat.eof)
					q_led.push_back(make_reply(PORT_LED, beat.data, 1'b1, 1'b1));
			end
			PORT_BUF_WR:
			begin
				// New frame replaces the old one
				if (beat.sof)
					buf_q.delete();
				if (buf_q.size() < BUF_DEPTH)
					buf_q.push_back(beat.data);
			end
			PORT_BUF_RD:
			begin
				if (beat.eof && buf_q.size() == 0)
					q_rd.push_back(make_reply(PORT_BUF_RD, 8'h00, 1'b1, 1'b1));
				else if (beat.eof)
				begin
					for (i = 0; i < buf_q.size(); i++)
						q_rd.push_back(make_reply(PORT_BUF_RD, buf_q[i], i == 0,
							i == buf_q.size() - 1));
				end
			end
			default:
			begin
				// Unowned port, nothing changes
			end
		endcase
	endtask

	// Oldest expected beat for a return port
	task automatic take_expected(input port_t port, output reply_t exp, output logic found);
		exp   = '0;
		found = 1'b0;
		if (port == PORT_DIP && q_dip.size() > 0)
		begin
			exp   = q_dip.pop_front();
			found = 1'b1;
		end
		else if (port == PORT_LED && q_led.size() > 0)
		begin
			exp   = q_led.pop_front();
			found = 1'b1;
		end
		else if (port == PORT_BUF_RD && q_rd.size() > 0)
		begin
			exp   = q_rd.pop_front();
			found = 1'b1;
		end
	endtask

endmodule

// ==== verification/chan_node_tb.sv ====
// Random frames on ports 1 to 5 with random return stalls; BUF_DEPTH set here and passed down
module chan_node_tb
	import chan_stream_pkg::*, chan_map_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int          BUF_DEPTH       = 16;
	localparam int          CLK_PERIOD      = 100;
	localparam int          SETTLE          = 10;
	localparam int          RAND_REQ        = 74;
	localparam int          NUM_REQ         = RAND_REQ + 6;
	localparam int          WATCHDOG_CYCLES = NUM_REQ * 200 + 1000;
	localparam logic [31:0] SEED            = 32'h07aa1cd8;
	localparam port_t       PORT_NONE       = 4'd5;

	logic  clk_local = 1'b0;
	logic  rst_local;
	beat_t out_beat;
	logic  out_src_rdy;
	port_t outport;
	logic  out_dst_rdy;
	beat_t in_beat;
	logic  in_src_rdy;
	logic  in_dst_rdy;
	port_t inport;
	byte_t dip;
	byte_t leds;

	integer seed;
	integer stall_seed;
	int     n;
	port_t  port;
	int     len;

	// Return frame tracking
	logic   in_frame;
	port_t  frame_port;

	always #(CLK_PERIOD / 2) clk_local = ~clk_local;

	chan_node_top #(
		.BUF_DEPTH (BUF_DEPTH)
	) dut0 (
		.clk_local   (clk_local),
		.rst_local   (rst_local),
		.out_beat    (out_beat),
		.out_src_rdy (out_src_rdy),
		.outport     (outport),
		.out_dst_rdy (out_dst_rdy),
		.in_beat     (in_beat),
		.in_src_rdy  (in_src_rdy),
		.in_dst_rdy  (in_dst_rdy),
		.inport      (inport),
		.dip         (dip),
		.leds        (leds)
	);

	chan_node_model #(
		.BUF_DEPTH (BUF_DEPTH)
	) model0 ();

	// --------------------
	// Helpers
	// --------------------

	task automatic abort_run();
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("[ERROR] t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
			abort_run();
		end
	endtask

	function automatic int rand_below(int limit);
		return int'($unsigned($random(seed)) % limit);
	endfunction

	// One request frame with random gaps and held stalls
	task automatic send_frame(input port_t req_port, input int req_len);
		byte_t data_q [$];
		beat_t beat;
		int    idx;
		int    k;
		logic  offered;
		idx     = 0;
		offered = 1'b0;
		for (k = 0; k < req_len; k++)
			data_q.push_back(byte_t'($random(seed)));
		while (idx < req_len)
		begin
			@(negedge clk_local);
			if (!offered)
			begin
				if (rand_below(4) == 0)
					out_src_rdy = 1'b0;
				else
				begin
					beat.sof    = (idx == 0);
					beat.eof    = (idx == req_len - 1);
					beat.data   = data_q[idx];
					out_beat    = beat;
					outport     = req_port;
					out_src_rdy = 1'b1;
				end
			end
			// Ready only moves on the rising edge
			#(SETTLE);
			offered = out_src_rdy && !out_dst_rdy;
			if (out_src_rdy && out_dst_rdy)
			begin
				model0.accept_beat(req_port, out_beat);
				idx++;
			end
		end
		@(negedge clk_local);
		out_src_rdy = 1'b0;
		check_value("leds", 32'(leds), 32'(model0.led_state()));
	endtask

	task automatic drain_replies();
		while (model0.pending() != 0)
			@(negedge clk_local);
		// Last beat leaves on the following edge
		@(negedge clk_local);
	endtask

	// New switch value with nothing in flight
	task automatic change_dip();
		drain_replies();
		dip = byte_t'($random(seed));
		model0.set_dip(dip);
		@(negedge clk_local);
	endtask

	task automatic check_reply();
		reply_t exp;
		logic   found;
		// Different port inside an open frame means interleaving
		if (in_frame)
			check_value("inport", 32'(inport), 32'(frame_port));
		model0.take_expected(inport, exp, found);
		if (!found)
		begin
			$display("Reply beat on inport %0d at %0t has no outstanding request", inport, $time);
			abort_run();
		end
		check_value("in_beat.data", 32'(in_beat.data), 32'(exp.beat.data));
		check_value("in_beat.sof", 32'(in_beat.sof), 32'(exp.beat.sof));
		check_value("in_beat.eof", 32'(in_beat.eof), 32'(exp.beat.eof));
		in_frame   = !in_beat.eof;
		frame_port = inport;
	endtask

	// --------------------
	// Return stream
	// --------------------

	initial
	begin
		// Own seed so stalls leave the request sequence alone
		stall_seed = SEED + 32'd1;
		in_dst_rdy = 1'b0;
		in_frame   = 1'b0;
		frame_port = '0;
		forever
		begin
			@(negedge clk_local);
			if (!rst_local)
				in_dst_rdy = ($random(stall_seed) & 3) != 0;
			#(SETTLE);
			if (!rst_local && in_src_rdy && in_dst_rdy)
				check_reply();
		end
	end

	// --------------------
	// Stimulus
	// --------------------

	initial
	begin
		seed        = SEED;
		rst_local   = 1'b1;
		out_beat    = '0;
		out_src_rdy = 1'b0;
		outport     = '0;
		dip         = byte_t'($random(seed));
		model0.set_dip(dip);
		repeat (3)
			@(posedge clk_local);
		@(negedge clk_local);
		rst_local = 1'b0;

		// Quiet after reset
		repeat (4)
		begin
			@(negedge clk_local);
			#(SETTLE);
			check_value("in_src_rdy", 32'(in_src_rdy), 0);
			check_value("leds", 32'(leds), 0);
			check_value("out_dst_rdy", 32'(out_dst_rdy), 1);
		end

		// Directed corners with empty replay and truncation first
		send_frame(PORT_BUF_RD, 1);
		send_frame(PORT_DIP, 1);
		send_frame(PORT_LED, 3);
		send_frame(PORT_BUF_WR, BUF_DEPTH + 3);
		send_frame(PORT_BUF_RD, 2);
		send_frame(PORT_NONE, 4);
		drain_replies();

		for (n = 0; n < RAND_REQ; n++)
		begin
			if (n % 16 == 15)
				change_dip();
			port = port_t'(1 + rand_below(5));
			len  = 1 + rand_below(BUF_DEPTH + 4);
			send_frame(port, len);
			repeat (rand_below(3))
				@(negedge clk_local);
		end

		drain_replies();
		repeat (20)
			@(negedge clk_local);
		if (in_src_rdy !== 1'b0 || model0.pending() != 0)
		begin
			$display("Return stream still busy or replies missing at end of run");
			abort_run();
		end
		else
		begin
			$display("All tests passed!");
			$finish;
		end
	end

	// Watchdog sized from the request count
	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		abort_run();
	end

endmodule
